// ==== Makefile ====
# Verilator build for the read/write address generator

VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_rw_gen
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/rw_gen_config_regs.sv ====
//----------------------------------------------------------------------
// Job configuration registers
// Captures one job per handshake and holds it until the job ends
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rw_gen_config_regs (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  rw_gen_pkg::addr_t  cfg_array_pointer,
    input  rw_gen_pkg::shift_t cfg_shift,
    input  rw_gen_pkg::count_t cfg_count,
    input  logic               cfg_write,
    input  logic               job_idle,
    input  logic               job_end,
    rw_param_if.cfg            params
);

    logic cfg_fire;

    // Only accept a job while nothing is running
    assign cfg_ready = job_idle;
    assign cfg_fire  = cfg_valid & cfg_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            params.param_valid <= 1'b0;
        end
        else if (job_end) begin
            params.param_valid <= 1'b0;
        end
        else if (cfg_fire) begin
            params.param_valid <= 1'b1;
        end
    end

    // Job fields
    always_ff @(posedge ap_clk) begin
        if (cfg_fire) begin
            params.array_pointer <= cfg_array_pointer;
            params.shift         <= cfg_shift;
            params.count         <= cfg_count;
            params.write         <= cfg_write;
        end
    end

endmodule : rw_gen_config_regs

`default_nettype wire

// ==== rtl/rw_gen_kernel.sv ====
//----------------------------------------------------------------------
// Address kernel
// Two stages turning a data word into a memory request
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rw_gen_kernel (
    input  logic              ap_clk,
    input  logic              areset_generator,
    rw_param_if.kern          params,
    input  logic              item_fire,
    input  rw_gen_pkg::data_t in_data,
    output logic              kernel_busy,
    output logic              push,
    output rw_gen_pkg::addr_t push_addr,
    output rw_gen_pkg::data_t push_data,
    output logic              push_write
);
    import rw_gen_pkg::*;

    logic [KERNEL_STAGES-1:0] stage_valid;
    addr_t                    s1_offset;
    data_t                    s1_data;

    // One valid bit per stage
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            stage_valid <= '0;
        end
        else begin
            stage_valid <= {stage_valid[KERNEL_STAGES-2:0], item_fire};
        end
    end

    // Stage 1: scale index by element size
    always_ff @(posedge ap_clk) begin
        s1_offset <= addr_t'(in_data) << params.shift;
        s1_data   <= in_data;
    end

    // Stage 2: add base pointer, attach command
    always_ff @(posedge ap_clk) begin
        push_addr  <= params.array_pointer + s1_offset;
        push_data  <= s1_data;
        push_write <= params.write;
    end

    assign push        = stage_valid[KERNEL_STAGES-1];
    assign kernel_busy = |stage_valid;

endmodule : rw_gen_kernel

`default_nettype wire

// ==== rtl/rw_gen_pkg.sv ====
//----------------------------------------------------------------------
// Read/write generator shared definitions
// Widths, state encoding and request FIFO sizing
//----------------------------------------------------------------------
`default_nettype none

package rw_gen_pkg;

    // Vector types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] count_t;
    typedef logic [2:0]  shift_t;

    // Job FSM
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DRAIN
    } job_state_t;

    //------------------------------------------------------------------
    // Request FIFO sizing
    //------------------------------------------------------------------
    localparam int REQ_FIFO_DEPTH       = 8;
    // Leaves room for the items still inside the kernel
    localparam int REQ_FIFO_ALMOST_FULL = 5;
    localparam int REQ_FIFO_PTR_W       = $clog2(REQ_FIFO_DEPTH);

    localparam int KERNEL_STAGES = 2;

endpackage : rw_gen_pkg

`default_nettype wire

// ==== rtl/rw_gen_request_fifo.sv ====
//----------------------------------------------------------------------
// Request FIFO toward memory, first-word output
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rw_gen_request_fifo (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              push,
    input  rw_gen_pkg::addr_t push_addr,
    input  rw_gen_pkg::data_t push_data,
    input  logic              push_write,
    output logic              req_valid,
    input  logic              req_ready,
    output rw_gen_pkg::addr_t req_addr,
    output rw_gen_pkg::data_t req_data,
    output logic              req_write,
    output logic              fifo_almost_full,
    output logic              fifo_empty
);
    import rw_gen_pkg::*;

    addr_t mem_addr  [REQ_FIFO_DEPTH];
    data_t mem_data  [REQ_FIFO_DEPTH];
    logic  mem_write [REQ_FIFO_DEPTH];

    logic [REQ_FIFO_PTR_W-1:0] wr_ptr;
    logic [REQ_FIFO_PTR_W-1:0] rd_ptr;
    logic [REQ_FIFO_PTR_W:0]   fill;
    logic                      pop;

    assign pop = req_valid & req_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the level
            if (push & ~pop) begin
                fill <= fill + 1'b1;
            end
            else if (pop & ~push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem_addr[wr_ptr]  <= push_addr;
            mem_data[wr_ptr]  <= push_data;
            mem_write[wr_ptr] <= push_write;
        end
    end

    // Head entry presented directly
    assign req_valid = (fill != '0);
    assign req_addr  = mem_addr[rd_ptr];
    assign req_data  = mem_data[rd_ptr];
    assign req_write = mem_write[rd_ptr];

    assign fifo_empty       = (fill == '0);
    assign fifo_almost_full = (fill >= (REQ_FIFO_PTR_W + 1)'(REQ_FIFO_ALMOST_FULL));

endmodule : rw_gen_request_fifo

`default_nettype wire

// ==== rtl/rw_gen_response_path.sv ====
//----------------------------------------------------------------------
// Response path to the engine, with outstanding read counter
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rw_gen_response_path (
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  logic              read_issued,
    input  logic              rsp_in_valid,
    output logic              rsp_in_ready,
    input  rw_gen_pkg::data_t rsp_in_data,
    output logic              eng_valid,
    input  logic              eng_ready,
    output rw_gen_pkg::data_t eng_data,
    output logic              pending_zero
);
    import rw_gen_pkg::*;

    count_t pending;
    logic   rsp_fire;

    // Register can take a word when empty or draining this cycle
    assign rsp_in_ready = ~eng_valid | eng_ready;
    assign rsp_fire     = rsp_in_valid & rsp_in_ready;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            eng_valid <= 1'b0;
            pending   <= '0;
        end
        else begin
            if (rsp_fire) begin
                eng_valid <= 1'b1;
            end
            else if (eng_ready) begin
                eng_valid <= 1'b0;
            end
            if (read_issued & ~rsp_fire) begin
                pending <= pending + count_t'(1);
            end
            else if (rsp_fire & ~read_issued) begin
                pending <= pending - count_t'(1);
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rsp_fire) begin
            eng_data <= rsp_in_data;
        end
    end

    assign pending_zero = (pending == '0);

endmodule : rw_gen_response_path

`default_nettype wire

// ==== rtl/rw_gen_sequencer.sv ====
//----------------------------------------------------------------------
// Job sequencer
// Counts accepted items, throttles input and signals completion
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rw_gen_sequencer (
    input  logic     ap_clk,
    input  logic     areset_generator,
    rw_param_if.seq  params,
    input  logic     in_valid,
    output logic     in_ready,
    output logic     item_fire,
    input  logic     kernel_busy,
    input  logic     fifo_almost_full,
    input  logic     fifo_empty,
    input  logic     pending_zero,
    output logic     job_idle,
    output logic     job_end,
    output logic     done
);
    import rw_gen_pkg::*;

    job_state_t state;
    job_state_t next_state;
    count_t     accepted;
    logic       all_accepted;
    logic       drained;

    assign all_accepted = (accepted == params.count);
    // Kernel, request queue and outstanding reads all empty
    assign drained      = ~kernel_busy & fifo_empty & pending_zero;

    // param_valid still high during done, so no new job yet
    assign job_idle  = (state == IDLE) & ~params.param_valid;
    assign in_ready  = (state == BUSY) & ~all_accepted & ~fifo_almost_full;
    assign item_fire = in_valid & in_ready;
    assign job_end   = done;

    //------------------------------------------------------------------
    // Job FSM
    //------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (params.param_valid & ~done) begin
                    next_state = BUSY;
                end
            end
            BUSY: begin
                if (all_accepted) begin
                    next_state = DRAIN;
                end
            end
            DRAIN: begin
                if (drained) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state    <= IDLE;
            accepted <= '0;
            done     <= 1'b0;
        end
        else begin
            state <= next_state;
            done  <= (state == DRAIN) & drained;
            if (state == IDLE) begin
                accepted <= '0;
            end
            else if (item_fire) begin
                accepted <= accepted + count_t'(1);
            end
        end
    end

endmodule : rw_gen_sequencer

`default_nettype wire

// ==== rtl/rw_gen_top.sv ====
//----------------------------------------------------------------------
// Read/write address generator top level
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rw_gen_top (
    input  logic               ap_clk,
    input  logic               areset,
    // Configuration
    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  rw_gen_pkg::addr_t  cfg_array_pointer,
    input  rw_gen_pkg::shift_t cfg_shift,
    input  rw_gen_pkg::count_t cfg_count,
    input  logic               cfg_write,
    // Data words in
    input  logic               in_valid,
    output logic               in_ready,
    input  rw_gen_pkg::data_t  in_data,
    // Memory requests
    output logic               req_valid,
    input  logic               req_ready,
    output rw_gen_pkg::addr_t  req_addr,
    output rw_gen_pkg::data_t  req_data,
    output logic               req_write,
    // Memory responses
    input  logic               rsp_in_valid,
    output logic               rsp_in_ready,
    input  rw_gen_pkg::data_t  rsp_in_data,
    // Engine output
    output logic               eng_valid,
    input  logic               eng_ready,
    output rw_gen_pkg::data_t  eng_data,
    output logic               done
);
    import rw_gen_pkg::*;

    logic  areset_generator;
    logic  job_idle;
    logic  job_end;
    logic  item_fire;
    logic  kernel_busy;
    logic  push;
    addr_t push_addr;
    data_t push_data;
    logic  push_write;
    logic  fifo_almost_full;
    logic  fifo_empty;
    logic  read_issued;
    logic  pending_zero;

    rw_param_if params ();

    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    // Only reads expect a response
    assign read_issued = req_valid & req_ready & ~req_write;

    //------------------------------------------------------------------
    // Control
    //------------------------------------------------------------------
    rw_gen_config_regs u_config_regs (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .cfg_valid         (cfg_valid),
        .cfg_ready         (cfg_ready),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_shift         (cfg_shift),
        .cfg_count         (cfg_count),
        .cfg_write         (cfg_write),
        .job_idle          (job_idle),
        .job_end           (job_end),
        .params            (params.cfg)
    );

    rw_gen_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .params           (params.seq),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .item_fire        (item_fire),
        .kernel_busy      (kernel_busy),
        .fifo_almost_full (fifo_almost_full),
        .fifo_empty       (fifo_empty),
        .pending_zero     (pending_zero),
        .job_idle         (job_idle),
        .job_end          (job_end),
        .done             (done)
    );

    //------------------------------------------------------------------
    // Data path
    //------------------------------------------------------------------
    rw_gen_kernel u_kernel (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .params           (params.kern),
        .item_fire        (item_fire),
        .in_data          (in_data),
        .kernel_busy      (kernel_busy),
        .push             (push),
        .push_addr        (push_addr),
        .push_data        (push_data),
        .push_write       (push_write)
    );

    rw_gen_request_fifo u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_addr        (push_addr),
        .push_data        (push_data),
        .push_write       (push_write),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_addr         (req_addr),
        .req_data         (req_data),
        .req_write        (req_write),
        .fifo_almost_full (fifo_almost_full),
        .fifo_empty       (fifo_empty)
    );

    rw_gen_response_path u_response_path (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .read_issued      (read_issued),
        .rsp_in_valid     (rsp_in_valid),
        .rsp_in_ready     (rsp_in_ready),
        .rsp_in_data      (rsp_in_data),
        .eng_valid        (eng_valid),
        .eng_ready        (eng_ready),
        .eng_data         (eng_data),
        .pending_zero     (pending_zero)
    );

endmodule : rw_gen_top

`default_nettype wire

// ==== rtl/rw_param_if.sv ====
//----------------------------------------------------------------------
// Job parameter bundle, loaded by the config block
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface rw_param_if;
    import rw_gen_pkg::*;

    logic   param_valid;
    addr_t  array_pointer;
    shift_t shift;
    count_t count;
    logic   write;

    modport cfg (
        output param_valid, array_pointer, shift, count, write
    );

    modport seq (
        input param_valid, count
    );

    modport kern (
        input array_pointer, shift, write
    );

endinterface : rw_param_if

`default_nettype wire

// ==== sources.f ====
rtl/rw_gen_pkg.sv
rtl/rw_param_if.sv
rtl/rw_gen_config_regs.sv
rtl/rw_gen_sequencer.sv
rtl/rw_gen_kernel.sv
rtl/rw_gen_request_fifo.sv
rtl/rw_gen_response_path.sv
rtl/rw_gen_top.sv
tb/tb_rw_gen.sv

// ==== tb/tb_rw_gen.sv ====
//----------------------------------------------------------------------
// Testbench for the read/write address generator
// Memory model, request and response scoreboards, protocol checks
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_rw_gen;
    import rw_gen_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;

    logic   ap_clk;
    logic   areset            = 1'b1;
    logic   cfg_valid         = 1'b0;
    logic   cfg_ready;
    addr_t  cfg_array_pointer = '0;
    shift_t cfg_shift         = '0;
    count_t cfg_count         = '0;
    logic   cfg_write         = 1'b0;
    logic   in_valid          = 1'b0;
    logic   in_ready;
    data_t  in_data           = '0;
    logic   req_valid;
    logic   req_ready         = 1'b0;
    addr_t  req_addr;
    data_t  req_data;
    logic   req_write;
    logic   rsp_in_valid      = 1'b0;
    logic   rsp_in_ready;
    data_t  rsp_in_data       = '0;
    logic   eng_valid;
    logic   eng_ready         = 1'b0;
    data_t  eng_data;
    logic   done;

    integer seed = 32'hb920_8476;
    int     cycle_count = 0;
    int     check_count = 0;
    int     error_count = 0;
    int     test_count  = 0;
    logic   checks_on   = 1'b0;
    logic   random_req_ready = 1'b0;

    // Current job as the testbench configured it
    addr_t  job_ptr;
    shift_t job_shift;
    count_t job_count;
    logic   job_write;
    logic   job_active = 1'b0;
    logic   after_done = 1'b0;
    int     in_count;
    int     req_count;
    int     read_count;
    int     rsp_count;

    // Scoreboards and memory model queues
    addr_t  exp_addr_q [$];
    data_t  exp_data_q [$];
    logic   exp_write_q [$];
    data_t  eng_exp_q [$];
    data_t  rsp_q [$];
    int     rsp_pops = 0;
    int     rsp_seen = 0;
    addr_t  exp_a;
    data_t  exp_d;
    logic   exp_w;

    rw_gen_top u_rw_gen_top (.*);

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    task automatic note_failure(input string what);
        $display("%0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (expected === actual)
            else begin
                $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                         $time, name, expected, actual);
                error_count++;
            end
    endtask

    task automatic log_test_result(input string name, input int errors_before);
        test_count++;
        $display("test %0d %s: %s, %0d errors", test_count, name,
                 (error_count == errors_before) ? "ok" : "FAILED",
                 error_count - errors_before);
    endtask

    //------------------------------------------------------------------
    // Monitor, scoreboards and protocol checks
    //------------------------------------------------------------------
    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
        else if (checks_on) begin
            check_count += 2;
            assert (!(job_active && cfg_ready))
                else note_failure("cfg_ready is high while a job is running");
            assert (!(in_ready && (!job_active || in_count == int'(job_count))))
                else note_failure("in_ready is high outside the busy phase of a job");
            if (after_done) begin
                check_value("cfg_ready after done", 32'd1, 32'(cfg_ready));
            end
            after_done = 1'b0;
            if (cfg_valid && cfg_ready) begin
                job_active = 1'b1;
                in_count   = 0;
                req_count  = 0;
                read_count = 0;
                rsp_count  = 0;
            end
            // Address is base plus index times element size
            if (in_valid && in_ready) begin
                exp_addr_q.push_back(job_ptr + in_data * (32'd1 << job_shift));
                exp_data_q.push_back(in_data);
                exp_write_q.push_back(job_write);
                in_count++;
            end
            if (req_valid && req_ready) begin
                if (exp_addr_q.size() == 0) begin
                    note_failure("request issued with no data word behind it");
                end
                else begin
                    exp_a = exp_addr_q.pop_front();
                    exp_d = exp_data_q.pop_front();
                    exp_w = exp_write_q.pop_front();
                    check_value("req_addr", exp_a, req_addr);
                    check_value("req_data", exp_d, req_data);
                    check_value("req_write", 32'(exp_w), 32'(req_write));
                    req_count++;
                    // Memory answers a read with the inverted address
                    if (!req_write) begin
                        read_count++;
                        rsp_q.push_back(~req_addr);
                        eng_exp_q.push_back(~exp_a);
                    end
                end
            end
            if (rsp_in_valid && rsp_in_ready) begin
                rsp_q.delete(0);
                rsp_pops++;
                rsp_count++;
            end
            if (eng_valid && eng_ready) begin
                if (eng_exp_q.size() == 0) begin
                    note_failure("engine output delivered a word nobody asked for");
                end
                else begin
                    check_value("eng_data", eng_exp_q.pop_front(), eng_data);
                end
            end
            if (done) begin
                check_count++;
                assert (job_active) else note_failure("done pulsed outside a job");
                check_value("requests at done", 32'(job_count), 32'(req_count));
                check_value("responses at done", 32'(read_count), 32'(rsp_count));
                check_value("pending requests at done", 32'd0, 32'(exp_addr_q.size()));
                job_active = 1'b0;
                after_done = 1'b1;
            end
        end
    end

    //------------------------------------------------------------------
    // Memory model and engine sink
    //------------------------------------------------------------------
    always @(negedge ap_clk) begin
        req_ready = random_req_ready ? (($random(seed) & 1) == 1) : 1'b1;
        eng_ready = (($random(seed) & 3) != 0);
        if (rsp_pops != rsp_seen) begin
            rsp_in_valid = 1'b0;
            rsp_seen     = rsp_pops;
        end
        // Random delay before each response goes out
        if (!rsp_in_valid && rsp_q.size() != 0 && (($random(seed) & 3) == 0)) begin
            rsp_in_valid = 1'b1;
            rsp_in_data  = rsp_q[0];
        end
    end

    task automatic run_job(input string name, input addr_t ptr, input shift_t shamt,
                           input count_t n, input logic wr, input logic rnd_req);
        int    errors_before;
        int    i;
        logic  gap;
        data_t next_word;
        errors_before = error_count;
        @(negedge ap_clk);
        job_ptr           = ptr;
        job_shift         = shamt;
        job_count         = n;
        job_write         = wr;
        cfg_array_pointer = ptr;
        cfg_shift         = shamt;
        cfg_count         = n;
        cfg_write         = wr;
        cfg_valid         = 1'b1;
        @(posedge ap_clk);
        while (!cfg_ready) @(posedge ap_clk);
        random_req_ready = rnd_req;
        next_word = $random(seed);
        for (i = 0; i < int'(n); i++) begin
            gap = (($random(seed) & 3) == 0);
            @(negedge ap_clk);
            cfg_valid = 1'b0;
            if (gap) begin
                in_valid = 1'b0;
                @(negedge ap_clk);
            end
            in_valid = 1'b1;
            in_data  = next_word;
            @(posedge ap_clk);
            while (!in_ready) @(posedge ap_clk);
            next_word = $random(seed);
        end
        @(negedge ap_clk);
        in_valid  = 1'b0;
        cfg_valid = 1'b0;
        @(posedge ap_clk);
        while (!done) @(posedge ap_clk);
        // Past the edge where the cfg_ready return is checked
        repeat (2) @(negedge ap_clk);
        log_test_result(name, errors_before);
    endtask

    //------------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------------
    initial begin
        int errors_before;
        errors_before = error_count;
        repeat (2) @(negedge ap_clk);
        areset = 1'b0;
        repeat (2) @(negedge ap_clk);
        check_value("cfg_ready", 32'd1, 32'(cfg_ready));
        check_value("in_ready", 32'd0, 32'(in_ready));
        check_value("req_valid", 32'd0, 32'(req_valid));
        check_value("eng_valid", 32'd0, 32'(eng_valid));
        check_value("done", 32'd0, 32'(done));
        @(negedge ap_clk);
        checks_on = 1'b1;
        log_test_result("state after reset", errors_before);

        run_job("read job, no back-pressure", 32'h1000_0000, 3'd2, 16'd12, 1'b0, 1'b0);
        run_job("write job, random req_ready", 32'h2000_0100, 3'd3, 16'd24, 1'b1, 1'b1);
        run_job("read responses", 32'h3000_0040, 3'd0, 16'd16, 1'b0, 1'b1);
        run_job("second job parameters", 32'h0000_8000, 3'd1, 16'd8, 1'b0, 1'b1);

        // Let the engine sink take the last responses
        while (eng_exp_q.size() != 0) @(negedge ap_clk);
        check_value("unanswered reads", 32'd0, 32'(rsp_q.size()));
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_rw_gen

`default_nettype wire
